//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_soc_misc
LOG ?= sim.log
FILELIST ?= soc_misc.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/flash_select_seq.sv
// flash_select_seq module: flash select bit, delayed select clock pulse and FPGA reload request
`timescale 1ns/10ps
`default_nettype none

module flash_select_seq (
	input  wire logic                     clk48m,
	input  wire logic                     rst,
	input  wire logic                     wr_en,
	input  wire soc_misc_pkg::reg_index_t wr_index,
	input  wire soc_misc_pkg::bus_word_t  wr_data,
	output logic                          fsel_d,
	output logic                          fsel_c,
	output logic                          programn
);

	logic       sel_wr;
	logic       fsel_strobe;
	logic       reload_armed;
	logic       fpga_reload;
	logic [2:0] fsel_delay;

	assign sel_wr = wr_en && (wr_index == soc_misc_pkg::REG_FLASH_SEL);

	// latch select bit, key check and a one cycle start strobe
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_d <= 1'b0;
			fsel_strobe <= 1'b0;
			reload_armed <= 1'b0;
		end else begin
			fsel_strobe <= sel_wr;
			if (sel_wr) begin
				fsel_d <= wr_data[0];
				reload_armed <= (wr_data[31:8] == soc_misc_pkg::FSEL_MAGIC);
			end
		end
	end

	// the select flip-flop gets its data well before its clock,
	// and the clock is back low before programn is pulled
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay <= '0;
			fpga_reload <= 1'b0;
		end else if (fsel_strobe) begin
			fsel_delay <= soc_misc_pkg::FSEL_DELAY_START;
		end else if (fsel_delay != 3'd0) begin
			fsel_delay <= fsel_delay - 3'd1;
			// reload is sticky, only reset brings programn back up
			if (fsel_delay == 3'd1 && reload_armed) begin
				fpga_reload <= 1'b1;
			end
		end
	end

	assign fsel_c = (fsel_delay <= soc_misc_pkg::FSEL_PULSE_HI) &&
		(fsel_delay >= soc_misc_pkg::FSEL_PULSE_LO);
	assign programn = ~fpga_reload;

endmodule

`default_nettype wire

//--- hw/misc_bus_front.sv
// misc_bus_front module: region decode, write strobe, read data mux, ready and bus error
`timescale 1ns/10ps
`default_nettype none

module misc_bus_front (
	input  wire logic                       bus_valid,
	input  wire soc_misc_pkg::bus_word_t    bus_addr,
	input  wire soc_misc_pkg::bus_word_t    bus_wdata,
	input  wire soc_misc_pkg::byte_strobe_t bus_wstrb,
	input  wire soc_misc_pkg::btn_t         btn,
	input  wire soc_misc_pkg::genio_t       genio_in,
	input  wire soc_misc_pkg::sao_t         sao1_in,
	input  wire soc_misc_pkg::sao_t         sao2_in,
	input  wire soc_misc_pkg::pmod_t        pmod_in,
	input  wire logic                       fsel_d,
	port_readback_if.sink                   rb,
	output soc_misc_pkg::bus_word_t         bus_rdata,
	output logic                            bus_ready,
	output logic                            bus_error_irq,
	output logic                            wr_en,
	output soc_misc_pkg::reg_index_t        wr_index,
	output soc_misc_pkg::bus_word_t         wr_data
);

	soc_misc_pkg::region_t   region;
	soc_misc_pkg::reg_index_t index;
	logic                    misc_hit;
	soc_misc_pkg::btn_t      btn_inv;
	soc_misc_pkg::bus_word_t gpext_in_word;

	assign region = bus_addr[31:28];
	assign index = bus_addr[6:2];
	assign misc_hit = (region == soc_misc_pkg::REGION_MISC);

	// buttons are active low on the board
	assign btn_inv = ~btn;

	// only byte lane 0 qualifies a register write
	assign wr_en = misc_hit && bus_valid && bus_wstrb[0];
	assign wr_index = index;
	assign wr_data = bus_wdata;

	// no wait states, every access finishes in the cycle it is presented
	assign bus_ready = bus_valid;
	assign bus_error_irq = bus_valid && !misc_hit;

	always_comb begin
		gpext_in_word = '0;
		gpext_in_word[soc_misc_pkg::GPEXT_SAO1_LSB +: $bits(soc_misc_pkg::sao_t)] = sao1_in;
		gpext_in_word[soc_misc_pkg::GPEXT_SAO2_LSB +: $bits(soc_misc_pkg::sao_t)] = sao2_in;
		gpext_in_word[soc_misc_pkg::GPEXT_PMOD_LSB +: $bits(soc_misc_pkg::pmod_t)] = pmod_in;
	end

	always_comb begin
		if (!misc_hit) begin
			bus_rdata = soc_misc_pkg::BUS_ERROR_WORD;
		end else begin
			case (index)
				soc_misc_pkg::REG_LED:       bus_rdata = soc_misc_pkg::bus_word_t'(rb.led);
				soc_misc_pkg::REG_BTN:       bus_rdata = soc_misc_pkg::bus_word_t'(btn_inv);
				soc_misc_pkg::REG_FLASH_SEL: bus_rdata = soc_misc_pkg::bus_word_t'(fsel_d);
				soc_misc_pkg::REG_GENIO_IN:  bus_rdata = soc_misc_pkg::bus_word_t'(genio_in);
				soc_misc_pkg::REG_GENIO_OUT: bus_rdata = soc_misc_pkg::bus_word_t'(rb.genio_out);
				soc_misc_pkg::REG_GENIO_OE:  bus_rdata = soc_misc_pkg::bus_word_t'(rb.genio_oe);
				soc_misc_pkg::REG_GPEXT_IN:  bus_rdata = gpext_in_word;
				soc_misc_pkg::REG_GPEXT_OUT: bus_rdata = rb.gpext_out_word;
				soc_misc_pkg::REG_GPEXT_OE:  bus_rdata = rb.gpext_oe_word;
				// set/clear registers and unmapped slots read as zero
				default:                     bus_rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/port_readback_if.sv
// port_readback_if interface: port register values from the register bank to the bus front end
`timescale 1ns/10ps
`default_nettype none

interface port_readback_if;

	soc_misc_pkg::led_t   led;
	soc_misc_pkg::genio_t genio_out;
	soc_misc_pkg::genio_t genio_oe;
	// extension fields already packed at their bus positions
	soc_misc_pkg::bus_word_t gpext_out_word;
	soc_misc_pkg::bus_word_t gpext_oe_word;

	modport source (
		output led,
		output genio_out,
		output genio_oe,
		output gpext_out_word,
		output gpext_oe_word
	);

	modport sink (
		input led,
		input genio_out,
		input genio_oe,
		input gpext_out_word,
		input gpext_oe_word
	);

endinterface

`default_nettype wire

//--- hw/port_regs.sv
// port_regs module: LED, general IO and extension port registers with set and clear writes
`timescale 1ns/10ps
`default_nettype none

module port_regs (
	input  wire logic                     clk48m,
	input  wire logic                     rst,
	input  wire logic                     wr_en,
	input  wire soc_misc_pkg::reg_index_t wr_index,
	input  wire soc_misc_pkg::bus_word_t  wr_data,
	output soc_misc_pkg::led_t            led,
	output soc_misc_pkg::genio_t          genio_out,
	output soc_misc_pkg::genio_t          genio_oe,
	output soc_misc_pkg::sao_t            sao1_out,
	output soc_misc_pkg::sao_t            sao1_oe,
	output soc_misc_pkg::sao_t            sao2_out,
	output soc_misc_pkg::sao_t            sao2_oe,
	output soc_misc_pkg::pmod_t           pmod_out,
	output soc_misc_pkg::pmod_t           pmod_oe,
	output logic                          irda_sd,
	port_readback_if.source               rb
);

	soc_misc_pkg::led_t   wr_led;
	soc_misc_pkg::genio_t wr_genio;
	soc_misc_pkg::sao_t   wr_sao1;
	soc_misc_pkg::sao_t   wr_sao2;
	soc_misc_pkg::pmod_t  wr_pmod;
	logic                 wr_irda;

	// write data split into the register fields
	assign wr_led = wr_data[$bits(soc_misc_pkg::led_t)-1:0];
	assign wr_genio = wr_data[$bits(soc_misc_pkg::genio_t)-1:0];
	assign wr_sao1 = wr_data[soc_misc_pkg::GPEXT_SAO1_LSB +: $bits(soc_misc_pkg::sao_t)];
	assign wr_sao2 = wr_data[soc_misc_pkg::GPEXT_SAO2_LSB +: $bits(soc_misc_pkg::sao_t)];
	assign wr_pmod = wr_data[soc_misc_pkg::GPEXT_PMOD_LSB +: $bits(soc_misc_pkg::pmod_t)];
	assign wr_irda = wr_data[soc_misc_pkg::GPEXT_IRDA_BIT];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= '0;
			genio_out <= '0;
			genio_oe <= '0;
			sao1_out <= '0;
			sao1_oe <= '0;
			sao2_out <= '0;
			sao2_oe <= '0;
			pmod_out <= '0;
			pmod_oe <= '0;
			// transceiver stays shut down until software enables it
			irda_sd <= 1'b1;
		end else if (wr_en) begin
			case (wr_index)
				soc_misc_pkg::REG_LED: led <= wr_led;
				soc_misc_pkg::REG_GENIO_OUT: genio_out <= wr_genio;
				soc_misc_pkg::REG_GENIO_OE: genio_oe <= wr_genio;
				soc_misc_pkg::REG_GENIO_W2S: genio_out <= genio_out | wr_genio;
				soc_misc_pkg::REG_GENIO_W2C: genio_out <= genio_out & ~wr_genio;
				soc_misc_pkg::REG_GPEXT_OUT: begin
					sao1_out <= wr_sao1;
					sao2_out <= wr_sao2;
					pmod_out <= wr_pmod;
					irda_sd <= wr_irda;
				end
				// irda shutdown has no output enable of its own
				soc_misc_pkg::REG_GPEXT_OE: begin
					sao1_oe <= wr_sao1;
					sao2_oe <= wr_sao2;
					pmod_oe <= wr_pmod;
				end
				soc_misc_pkg::REG_GPEXT_W2S: begin
					sao1_out <= sao1_out | wr_sao1;
					sao2_out <= sao2_out | wr_sao2;
					pmod_out <= pmod_out | wr_pmod;
					irda_sd <= irda_sd | wr_irda;
				end
				soc_misc_pkg::REG_GPEXT_W2C: begin
					sao1_out <= sao1_out & ~wr_sao1;
					sao2_out <= sao2_out & ~wr_sao2;
					pmod_out <= pmod_out & ~wr_pmod;
					irda_sd <= irda_sd & ~wr_irda;
				end
				default: begin
				end
			endcase
		end
	end

	// readback to the bus front end
	assign rb.led = led;
	assign rb.genio_out = genio_out;
	assign rb.genio_oe = genio_oe;

	always_comb begin
		rb.gpext_out_word = '0;
		rb.gpext_out_word[soc_misc_pkg::GPEXT_SAO1_LSB +: $bits(soc_misc_pkg::sao_t)] = sao1_out;
		rb.gpext_out_word[soc_misc_pkg::GPEXT_SAO2_LSB +: $bits(soc_misc_pkg::sao_t)] = sao2_out;
		rb.gpext_out_word[soc_misc_pkg::GPEXT_PMOD_LSB +: $bits(soc_misc_pkg::pmod_t)] = pmod_out;
		rb.gpext_out_word[soc_misc_pkg::GPEXT_IRDA_BIT] = irda_sd;
	end

	always_comb begin
		rb.gpext_oe_word = '0;
		rb.gpext_oe_word[soc_misc_pkg::GPEXT_SAO1_LSB +: $bits(soc_misc_pkg::sao_t)] = sao1_oe;
		rb.gpext_oe_word[soc_misc_pkg::GPEXT_SAO2_LSB +: $bits(soc_misc_pkg::sao_t)] = sao2_oe;
		rb.gpext_oe_word[soc_misc_pkg::GPEXT_PMOD_LSB +: $bits(soc_misc_pkg::pmod_t)] = pmod_oe;
	end

endmodule

`default_nettype wire

//--- hw/soc_misc_pkg.sv
// misc register block package: types, region code, register map and flash-select constants
`default_nettype none

package soc_misc_pkg;

	// bus and register field widths
	typedef logic [31:0] bus_word_t;
	typedef logic [3:0]  byte_strobe_t;
	typedef logic [4:0]  reg_index_t;
	typedef logic [3:0]  region_t;
	typedef logic [8:0]  led_t;
	typedef logic [7:0]  btn_t;
	typedef logic [29:0] genio_t;
	typedef logic [5:0]  sao_t;
	typedef logic [7:0]  pmod_t;

	// top address nibble of the misc registers
	localparam region_t REGION_MISC = 4'h2;
	// read value for any undecoded region
	localparam bus_word_t BUS_ERROR_WORD = 32'hDEADBEEF;

	// upper 24 bits of a FLASH_SEL write that arm the FPGA reload
	localparam logic [23:0] FSEL_MAGIC = 24'hD0F1A5;
	// select clock is high while the delay count is between HI and LO
	localparam logic [2:0] FSEL_DELAY_START = 3'd7;
	localparam logic [2:0] FSEL_PULSE_HI = 3'd5;
	localparam logic [2:0] FSEL_PULSE_LO = 3'd3;

	// register indices, word address bits 6:2
	localparam reg_index_t REG_LED       = 5'd0;
	localparam reg_index_t REG_BTN       = 5'd1;
	localparam reg_index_t REG_FLASH_SEL = 5'd13;
	localparam reg_index_t REG_GENIO_IN  = 5'd17;
	localparam reg_index_t REG_GENIO_OUT = 5'd18;
	localparam reg_index_t REG_GENIO_OE  = 5'd19;
	localparam reg_index_t REG_GENIO_W2S = 5'd20;
	localparam reg_index_t REG_GENIO_W2C = 5'd21;
	localparam reg_index_t REG_GPEXT_IN  = 5'd22;
	localparam reg_index_t REG_GPEXT_OUT = 5'd23;
	localparam reg_index_t REG_GPEXT_OE  = 5'd24;
	localparam reg_index_t REG_GPEXT_W2S = 5'd25;
	localparam reg_index_t REG_GPEXT_W2C = 5'd26;

	// field positions inside the extension port words
	localparam int unsigned GPEXT_SAO1_LSB = 0;
	localparam int unsigned GPEXT_SAO2_LSB = 8;
	localparam int unsigned GPEXT_PMOD_LSB = 16;
	localparam int unsigned GPEXT_IRDA_BIT = 30;

endpackage

`default_nettype wire

//--- hw/soc_misc_top.sv
// soc_misc_top module: misc register block top level with bus front end, port registers and flash select
`timescale 1ns/10ps
`default_nettype none

module soc_misc_top (
	input  wire logic                       clk48m,
	input  wire logic                       rst,
	// cpu data bus
	input  wire logic                       bus_valid,
	input  wire soc_misc_pkg::bus_word_t    bus_addr,
	input  wire soc_misc_pkg::bus_word_t    bus_wdata,
	input  wire soc_misc_pkg::byte_strobe_t bus_wstrb,
	output soc_misc_pkg::bus_word_t         bus_rdata,
	output logic                            bus_ready,
	output logic                            bus_error_irq,
	// board pins
	input  wire soc_misc_pkg::btn_t         btn,
	output soc_misc_pkg::led_t              led,
	input  wire soc_misc_pkg::genio_t       genio_in,
	output soc_misc_pkg::genio_t            genio_out,
	output soc_misc_pkg::genio_t            genio_oe,
	input  wire soc_misc_pkg::sao_t         sao1_in,
	output soc_misc_pkg::sao_t              sao1_out,
	output soc_misc_pkg::sao_t              sao1_oe,
	input  wire soc_misc_pkg::sao_t         sao2_in,
	output soc_misc_pkg::sao_t              sao2_out,
	output soc_misc_pkg::sao_t              sao2_oe,
	input  wire soc_misc_pkg::pmod_t        pmod_in,
	output soc_misc_pkg::pmod_t             pmod_out,
	output soc_misc_pkg::pmod_t             pmod_oe,
	output logic                            irda_sd,
	// flash select and reconfiguration
	output logic                            fsel_d,
	output logic                            fsel_c,
	output logic                            programn
);

	logic                     wr_en;
	soc_misc_pkg::reg_index_t wr_index;
	soc_misc_pkg::bus_word_t  wr_data;

	port_readback_if i_port_readback_if ();

	misc_bus_front i_misc_bus_front (
		.bus_valid     (bus_valid),
		.bus_addr      (bus_addr),
		.bus_wdata     (bus_wdata),
		.bus_wstrb     (bus_wstrb),
		.btn           (btn),
		.genio_in      (genio_in),
		.sao1_in       (sao1_in),
		.sao2_in       (sao2_in),
		.pmod_in       (pmod_in),
		.fsel_d        (fsel_d),
		.rb            (i_port_readback_if.sink),
		.bus_rdata     (bus_rdata),
		.bus_ready     (bus_ready),
		.bus_error_irq (bus_error_irq),
		.wr_en         (wr_en),
		.wr_index      (wr_index),
		.wr_data       (wr_data)
	);

	port_regs i_port_regs (
		.clk48m    (clk48m),
		.rst       (rst),
		.wr_en     (wr_en),
		.wr_index  (wr_index),
		.wr_data   (wr_data),
		.led       (led),
		.genio_out (genio_out),
		.genio_oe  (genio_oe),
		.sao1_out  (sao1_out),
		.sao1_oe   (sao1_oe),
		.sao2_out  (sao2_out),
		.sao2_oe   (sao2_oe),
		.pmod_out  (pmod_out),
		.pmod_oe   (pmod_oe),
		.irda_sd   (irda_sd),
		.rb        (i_port_readback_if.source)
	);

	flash_select_seq i_flash_select_seq (
		.clk48m   (clk48m),
		.rst      (rst),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_data  (wr_data),
		.fsel_d   (fsel_d),
		.fsel_c   (fsel_c),
		.programn (programn)
	);

endmodule

`default_nettype wire

//--- soc_misc.f
hw/soc_misc_pkg.sv
hw/port_readback_if.sv
hw/misc_bus_front.sv
hw/port_regs.sv
hw/flash_select_seq.sv
hw/soc_misc_top.sv
test/tb_clock_gen.sv
test/tb_soc_misc.sv

//--- test/soc_misc_testdata.txt
// kind addr data strb expect aux; 1 write (aux irq), 2 read (expect rdata, aux irq), 3 inputs,
// 4 pins (addr ext, data genio_out, strb led, expect genio_oe, aux programn/fsel_c/fsel_d), 5 fsel, F end
4 40000000 00000000 0 00000000 4
2 20000048 00000000 0 00000000 0
2 2000004C 00000000 0 00000000 0
2 2000005C 00000000 0 40000000 0
1 20000000 FFFFF1A5 F 00000000 0
2 20000000 00000000 0 000001A5 0
1 20000048 12345678 1 00000000 0
1 2000004C FFFFFFFF F 00000000 0
2 2000004C 00000000 0 3FFFFFFF 0
1 20000050 21000001 F 00000000 0
2 20000048 00000000 0 33345679 0
1 20000054 02300070 F 00000000 0
1 20000048 00000000 2 00000000 0
2 20000048 00000000 0 31045609 0
1 2000005C 802AD5FC F 00000000 0
2 2000005C 00000000 0 002A153C 0
1 20000060 7FFFFFFF F 00000000 0
2 20000060 00000000 0 00FF3F3F 0
1 20000064 40C00203 F 00000000 0
2 2000005C 00000000 0 40EA173F 0
1 20000068 40880111 F 00000000 0
2 2000005C 00000000 0 0062162E 0
4 0062162E 31045609 1A5 3FFFFFFF 4
3 5AC32A15 2BADCAFE 0 00000000 0
2 20000044 00000000 0 2BADCAFE 0
2 20000058 00000000 0 00C32A15 0
2 20000004 00000000 0 000000A5 0
2 30000048 00000000 0 DEADBEEF 1
2 F000005C 00000000 0 DEADBEEF 1
1 10000048 FFFFFFFF F 00000000 1
2 20000048 00000000 0 31045609 0
2 20000014 00000000 0 00000000 0
5 20000034 00000001 F 00000001 1
2 20000034 00000000 0 00000001 0
5 20000034 D0F1A400 F 00000001 1
5 20000034 D0F1A501 F 00000000 1
4 0062162E 31045609 1A5 3FFFFFFF 1
5 20000034 00000000 F 00000000 0
F 00000000 00000000 0 00000000 0

//--- test/tb_clock_gen.sv
// tb_clock_gen module: 100 ns testbench clock and synchronous reset held for 8 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk48m,
	output logic rst
);

	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk48m = 1'b0;
		forever #HALF_PERIOD clk48m = ~clk48m;
	end

	// release reset on a falling edge, like every other stimulus
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk48m);
		@(negedge clk48m);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- test/tb_soc_misc.sv
// tb_soc_misc module: testbench top driving the misc register bus from the test data file
`timescale 1ns/10ps
`default_nettype none

module tb_soc_misc;

	localparam int MAX_OPS = 64;
	localparam int OP_WORDS = 6;

	logic clk48m;
	logic rst;
	logic bus_valid;
	soc_misc_pkg::bus_word_t bus_addr;
	soc_misc_pkg::bus_word_t bus_wdata;
	soc_misc_pkg::byte_strobe_t bus_wstrb;
	soc_misc_pkg::bus_word_t bus_rdata;
	logic bus_ready;
	logic bus_error_irq;
	soc_misc_pkg::btn_t btn;
	soc_misc_pkg::led_t led;
	soc_misc_pkg::genio_t genio_in;
	soc_misc_pkg::genio_t genio_out;
	soc_misc_pkg::genio_t genio_oe;
	soc_misc_pkg::sao_t sao1_in;
	soc_misc_pkg::sao_t sao1_out;
	soc_misc_pkg::sao_t sao1_oe;
	soc_misc_pkg::sao_t sao2_in;
	soc_misc_pkg::sao_t sao2_out;
	soc_misc_pkg::sao_t sao2_oe;
	soc_misc_pkg::pmod_t pmod_in;
	soc_misc_pkg::pmod_t pmod_out;
	soc_misc_pkg::pmod_t pmod_oe;
	logic irda_sd;
	logic fsel_d;
	logic fsel_c;
	logic programn;

	// six words per operation in the order kind, addr, data, strb, expect, aux
	soc_misc_pkg::bus_word_t tdata [0:MAX_OPS*OP_WORDS-1];
	int n_ops;
	int checks = 0;
	int errors = 0;
	int cycle_count = 0;
	int cycle_limit = MAX_OPS * 20 + 100;
	// extension output enables as last read back, zero out of reset
	soc_misc_pkg::bus_word_t gpext_oe_exp = '0;

	tb_clock_gen i_tb_clock_gen (
		.clk48m (clk48m),
		.rst    (rst)
	);

	soc_misc_top i_soc_misc_top (.*);

	task automatic check_word(input soc_misc_pkg::bus_word_t got,
		input soc_misc_pkg::bus_word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_genio(input soc_misc_pkg::genio_t got,
		input soc_misc_pkg::genio_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// present an access on the falling edge and let the combinational answer settle
	task automatic drive_bus(input soc_misc_pkg::bus_word_t addr,
		input soc_misc_pkg::bus_word_t data, input soc_misc_pkg::byte_strobe_t strb);
		@(negedge clk48m);
		bus_valid = 1'b1;
		bus_addr = addr;
		bus_wdata = data;
		bus_wstrb = strb;
		#10;
	endtask

	// the rising edge in between is the one that samples the access
	task automatic release_bus();
		@(negedge clk48m);
		bus_valid = 1'b0;
		bus_wstrb = '0;
	endtask

	// select clock high after E3 to E5 and programn follows the key from E8
	task automatic run_flash_select(input soc_misc_pkg::bus_word_t addr,
		input soc_misc_pkg::bus_word_t data, input soc_misc_pkg::byte_strobe_t strb,
		input logic prog_after, input logic prog_before, input int op);
		logic exp_c;
		logic exp_p;
		drive_bus(addr, data, strb);
		check_bit(bus_ready, 1'b1, $sformatf("op %0d flash select ready", op));
		release_bus();
		for (int k = 0; k <= 9; k++) begin
			if (k > 0) begin
				@(negedge clk48m);
			end
			exp_c = (k >= 3) && (k <= 5);
			exp_p = (k >= 8) ? prog_after : prog_before;
			check_bit(fsel_c, exp_c, $sformatf("op %0d fsel_c after E%0d", op, k));
			check_bit(programn, exp_p, $sformatf("op %0d programn after E%0d", op, k));
			check_bit(fsel_d, data[0], $sformatf("op %0d fsel_d after E%0d", op, k));
		end
	endtask

	task automatic check_pins(input soc_misc_pkg::bus_word_t ext_exp,
		input soc_misc_pkg::bus_word_t out_exp, input soc_misc_pkg::bus_word_t led_exp,
		input soc_misc_pkg::bus_word_t oe_exp, input soc_misc_pkg::bus_word_t flags, input int op);
		soc_misc_pkg::bus_word_t ext_pins;
		soc_misc_pkg::bus_word_t ext_oe_pins;
		@(negedge clk48m);
		ext_pins = '0;
		ext_pins[soc_misc_pkg::GPEXT_SAO1_LSB +: 6] = sao1_out;
		ext_pins[soc_misc_pkg::GPEXT_SAO2_LSB +: 6] = sao2_out;
		ext_pins[soc_misc_pkg::GPEXT_PMOD_LSB +: 8] = pmod_out;
		ext_pins[soc_misc_pkg::GPEXT_IRDA_BIT] = irda_sd;
		ext_oe_pins = '0;
		ext_oe_pins[soc_misc_pkg::GPEXT_SAO1_LSB +: 6] = sao1_oe;
		ext_oe_pins[soc_misc_pkg::GPEXT_SAO2_LSB +: 6] = sao2_oe;
		ext_oe_pins[soc_misc_pkg::GPEXT_PMOD_LSB +: 8] = pmod_oe;
		check_word(ext_pins, ext_exp, $sformatf("op %0d extension pins", op));
		check_word(ext_oe_pins, gpext_oe_exp, $sformatf("op %0d extension output enables", op));
		check_genio(genio_out, out_exp[29:0], $sformatf("op %0d genio_out", op));
		check_genio(genio_oe, oe_exp[29:0], $sformatf("op %0d genio_oe", op));
		check_word(soc_misc_pkg::bus_word_t'(led), led_exp, $sformatf("op %0d led", op));
		check_bit(programn, flags[2], $sformatf("op %0d programn", op));
		check_bit(fsel_c, flags[1], $sformatf("op %0d fsel_c", op));
		check_bit(fsel_d, flags[0], $sformatf("op %0d fsel_d", op));
	endtask

	always @(posedge clk48m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run went past %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		int base;
		bus_valid = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		bus_wstrb = '0;
		btn = '0;
		genio_in = '0;
		sao1_in = '0;
		sao2_in = '0;
		pmod_in = '0;
		$readmemh("test/soc_misc_testdata.txt", tdata);
		n_ops = 0;
		while (n_ops < MAX_OPS && tdata[n_ops*OP_WORDS] !== 32'hF) begin
			n_ops++;
		end
		if (n_ops == MAX_OPS) begin
			$display("test data has no end marker or could not be read");
			errors++;
			n_ops = 0;
		end
		cycle_limit = 20 * n_ops + 100;
		wait (rst == 1'b0);
		for (int op = 0; op < n_ops; op++) begin
			base = op * OP_WORDS;
			case (tdata[base])
				32'h1: begin
					drive_bus(tdata[base+1], tdata[base+2], tdata[base+3][3:0]);
					check_bit(bus_ready, 1'b1, $sformatf("op %0d write ready", op));
					check_bit(bus_error_irq, tdata[base+5][0], $sformatf("op %0d write irq", op));
					release_bus();
				end
				32'h2: begin
					drive_bus(tdata[base+1], '0, '0);
					check_word(bus_rdata, tdata[base+4], $sformatf("op %0d read data", op));
					check_bit(bus_ready, 1'b1, $sformatf("op %0d read ready", op));
					check_bit(bus_error_irq, tdata[base+5][0], $sformatf("op %0d read irq", op));
					release_bus();
					if (tdata[base+1][31:28] == soc_misc_pkg::REGION_MISC &&
						tdata[base+1][6:2] == soc_misc_pkg::REG_GPEXT_OE) begin
						gpext_oe_exp = tdata[base+4];
					end
				end
				32'h3: begin
					@(negedge clk48m);
					btn = tdata[base+1][31:24];
					pmod_in = tdata[base+1][23:16];
					sao2_in = tdata[base+1][13:8];
					sao1_in = tdata[base+1][5:0];
					genio_in = tdata[base+2][29:0];
				end
				32'h4: check_pins(tdata[base+1], tdata[base+2], tdata[base+3], tdata[base+4],
					tdata[base+5], op);
				32'h5: run_flash_select(tdata[base+1], tdata[base+2], tdata[base+3][3:0],
					tdata[base+4][0], tdata[base+5][0], op);
				default: begin
					$display("operation %0d has an unknown kind %h", op, tdata[base]);
					errors++;
				end
			endcase
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
